/* design/rv_consts.svh */
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// ====================
// Widths and sizes
// ====================
`define RV_XLEN         32
`define RV_REG_ADDR_W   5
`define RV_NUM_REGS     32

// First fetch address and PC step
`define RV_RESET_VECTOR 32'h0000_0000
`define RV_INSN_BYTES   32'd4

// ====================
// Major opcodes
// ====================
`define RV_OP_LUI       7'b0110111
`define RV_OP_JAL       7'b1101111
`define RV_OP_BRANCH    7'b1100011
`define RV_OP_LOAD      7'b0000011
`define RV_OP_STORE     7'b0100011
`define RV_OP_IMM       7'b0010011
`define RV_OP_REG       7'b0110011

// Funct3 values, branch codes overlap the ALU codes
`define RV_F3_ADD       3'b000
`define RV_F3_XOR       3'b100
`define RV_F3_OR        3'b110
`define RV_F3_AND       3'b111
`define RV_F3_BEQ       3'b000
`define RV_F3_BNE       3'b001
`define RV_F3_WORD      3'b010

`endif

/* design/rv_pkg.sv */
`include "rv_consts.svh"

package rv_pkg;

   // Data and address word
   typedef logic [`RV_XLEN-1:0] word_t;

   // Register index
   typedef logic [`RV_REG_ADDR_W-1:0] reg_idx_t;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_PASS_B
   } alu_op_e;

   // What follows execute
   typedef enum logic [2:0] {
      STEP_WRITEBACK,
      STEP_LOAD,
      STEP_STORE,
      STEP_BRANCH,
      STEP_JUMP,
      STEP_HALT
   } next_step_e;

endpackage

/* design/rv_bus_master.sv */
module rv_bus_master (
   input  logic          clk,
   input  logic          reset,
   input  logic          start_i,
   input  logic          write_i,
   input  rv_pkg::word_t addr_i,
   input  rv_pkg::word_t wdata_i,
   input  logic          ack_i,
   input  rv_pkg::word_t bus_dat_i,
   output rv_pkg::word_t adr_o,
   output rv_pkg::word_t dat_o,
   output logic          cyc_o,
   output logic          stb_o,
   output logic          we_o,
   output rv_pkg::word_t rdata_o,
   output logic          done_o
);
   import rv_pkg::*;

   logic  open_q;
   logic  we_q;
   logic  done_q;
   word_t adr_q;
   word_t dat_q;
   word_t rdata_q;

   always_ff @(posedge clk) begin
      if (reset) begin
         open_q <= 1'b0;
         we_q   <= 1'b0;
         done_q <= 1'b0;
      end else begin
         done_q <= 1'b0;
         if (!open_q && start_i) begin
            open_q <= 1'b1;
            we_q   <= write_i;
         end else if (open_q && ack_i) begin
            // Cycle ends, strobes drop next cycle
            open_q <= 1'b0;
            we_q   <= 1'b0;
            done_q <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!open_q && start_i) begin
         adr_q <= addr_i;
         dat_q <= wdata_i;
      end
      if (open_q && ack_i) begin
         rdata_q <= bus_dat_i;
      end
   end

   assign adr_o   = adr_q;
   assign dat_o   = dat_q;
   assign cyc_o   = open_q;
   assign stb_o   = open_q;
   assign we_o    = we_q;
   assign rdata_o = rdata_q;
   assign done_o  = done_q;

   a_stb_in_cyc: assert property (@(posedge clk) disable iff (reset) stb_o |-> cyc_o);

   a_adr_stable: assert property (@(posedge clk) disable iff (reset)
      (stb_o && !ack_i) |=> $stable(adr_o));

   // Control only ever hands out word addresses
   a_adr_aligned: assert property (@(posedge clk) disable iff (reset)
      stb_o |-> (adr_o[1:0] == 2'b00));

endmodule

/* design/rv_decoder.sv */
`include "rv_consts.svh"

module rv_decoder (
   input  logic               clk,
   input  logic               reset,
   input  logic               load_i,
   input  rv_pkg::word_t      insn_i,
   output rv_pkg::reg_idx_t   rs1_o,
   output rv_pkg::reg_idx_t   rs2_o,
   output rv_pkg::reg_idx_t   rd_o,
   output rv_pkg::word_t      imm_o,
   output rv_pkg::alu_op_e    alu_op_o,
   output logic               use_imm_o,
   output logic               write_reg_o,
   output logic               branch_on_ne_o,
   output rv_pkg::next_step_e step_o
);
   import rv_pkg::*;

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   word_t      imm_i_fmt;
   word_t      imm_s_fmt;
   word_t      imm_b_fmt;
   word_t      imm_u_fmt;
   word_t      imm_j_fmt;
   word_t      imm_d;
   alu_op_e    alu_op_d;
   logic       use_imm_d;
   logic       write_reg_d;
   logic       ne_d;
   next_step_e step_d;

   assign opcode = insn_i[6:0];
   assign funct3 = insn_i[14:12];
   assign funct7 = insn_i[31:25];

   // ====================
   // Immediate formats
   // ====================
   assign imm_i_fmt = {{20{insn_i[31]}}, insn_i[31:20]};
   assign imm_s_fmt = {{20{insn_i[31]}}, insn_i[31:25], insn_i[11:7]};
   assign imm_b_fmt = {{19{insn_i[31]}}, insn_i[31], insn_i[7], insn_i[30:25],
                       insn_i[11:8], 1'b0};
   assign imm_u_fmt = {insn_i[31:12], 12'b0};
   assign imm_j_fmt = {{11{insn_i[31]}}, insn_i[31], insn_i[19:12], insn_i[20],
                       insn_i[30:21], 1'b0};

   always_comb begin
      imm_d       = imm_i_fmt;
      alu_op_d    = ALU_ADD;
      use_imm_d   = 1'b1;
      write_reg_d = 1'b0;
      ne_d        = 1'b0;
      step_d      = STEP_HALT;
      case (opcode)
         `RV_OP_LUI: begin
            imm_d       = imm_u_fmt;
            alu_op_d    = ALU_PASS_B;
            write_reg_d = 1'b1;
            step_d      = STEP_WRITEBACK;
         end
         `RV_OP_JAL: begin
            imm_d       = imm_j_fmt;
            write_reg_d = 1'b1;
            step_d      = STEP_JUMP;
         end
         `RV_OP_BRANCH: begin
            imm_d     = imm_b_fmt;
            alu_op_d  = ALU_SUB;
            use_imm_d = 1'b0;
            ne_d      = (funct3 == `RV_F3_BNE);
            if (funct3 == `RV_F3_BEQ || funct3 == `RV_F3_BNE) begin
               step_d = STEP_BRANCH;
            end
         end
         `RV_OP_LOAD: begin
            write_reg_d = 1'b1;
            if (funct3 == `RV_F3_WORD) begin
               step_d = STEP_LOAD;
            end
         end
         `RV_OP_STORE: begin
            imm_d = imm_s_fmt;
            if (funct3 == `RV_F3_WORD) begin
               step_d = STEP_STORE;
            end
         end
         `RV_OP_IMM: begin
            // ADDI only
            write_reg_d = 1'b1;
            if (funct3 == `RV_F3_ADD) begin
               step_d = STEP_WRITEBACK;
            end
         end
         `RV_OP_REG: begin
            use_imm_d   = 1'b0;
            write_reg_d = 1'b1;
            case (funct3)
               `RV_F3_ADD: alu_op_d = funct7[5] ? ALU_SUB : ALU_ADD;
               `RV_F3_XOR: alu_op_d = ALU_XOR;
               `RV_F3_OR:  alu_op_d = ALU_OR;
               `RV_F3_AND: alu_op_d = ALU_AND;
               default:    alu_op_d = ALU_ADD;
            endcase
            // SUB is the only funct7 variant kept
            if ((funct7 == 7'h00) ||
                (funct7 == 7'h20 && funct3 == `RV_F3_ADD)) begin
               if (funct3 == `RV_F3_ADD || funct3 == `RV_F3_XOR ||
                   funct3 == `RV_F3_OR || funct3 == `RV_F3_AND) begin
                  step_d = STEP_WRITEBACK;
               end
            end
         end
         default: begin
            step_d = STEP_HALT;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         rs1_o          <= '0;
         rs2_o          <= '0;
         rd_o           <= '0;
         imm_o          <= '0;
         alu_op_o       <= ALU_ADD;
         use_imm_o      <= 1'b0;
         write_reg_o    <= 1'b0;
         branch_on_ne_o <= 1'b0;
         step_o         <= STEP_WRITEBACK;
      end else if (load_i) begin
         rs1_o          <= insn_i[19:15];
         rs2_o          <= insn_i[24:20];
         rd_o           <= insn_i[11:7];
         imm_o          <= imm_d;
         alu_op_o       <= alu_op_d;
         use_imm_o      <= use_imm_d;
         write_reg_o    <= write_reg_d && (step_d != STEP_HALT);
         branch_on_ne_o <= ne_d;
         step_o         <= step_d;
      end
   end

endmodule

/* design/rv_alu.sv */
module rv_alu (
   input  rv_pkg::word_t   a_i,
   input  rv_pkg::word_t   b_i,
   input  rv_pkg::alu_op_e op_i,
   output rv_pkg::word_t   result_o,
   output logic            equal_o
);
   import rv_pkg::*;

   word_t result;

   always_comb begin
      case (op_i)
         ALU_ADD:    result = a_i + b_i;
         ALU_SUB:    result = a_i - b_i;
         ALU_AND:    result = a_i & b_i;
         ALU_OR:     result = a_i | b_i;
         ALU_XOR:    result = a_i ^ b_i;
         // LUI passes its upper immediate
         ALU_PASS_B: result = b_i;
         default:    result = '0;
      endcase
   end

   assign result_o = result;

   // Branch compare
   assign equal_o = (a_i == b_i);

endmodule

/* design/rv_regfile.sv */
`include "rv_consts.svh"

module rv_regfile (
   input  logic             clk,
   input  rv_pkg::reg_idx_t rs1_i,
   input  rv_pkg::reg_idx_t rs2_i,
   input  rv_pkg::reg_idx_t rd_i,
   input  logic             we_i,
   input  rv_pkg::word_t    wdata_i,
   output rv_pkg::word_t    rdata1_o,
   output rv_pkg::word_t    rdata2_o
);
   import rv_pkg::*;

   // x0 has no storage
   word_t regs [1:`RV_NUM_REGS-1];

   always_ff @(posedge clk) begin
      if (we_i && rd_i != '0) begin
         regs[rd_i] <= wdata_i;
      end
   end

   assign rdata1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
   assign rdata2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

   a_x0_zero: assert property (@(posedge clk)
      ((rs1_i == '0) |-> (rdata1_o == '0)) and ((rs2_i == '0) |-> (rdata2_o == '0)));

endmodule

/* design/rv_control.sv */
`include "rv_consts.svh"

module rv_control (
   input  logic               clk,
   input  logic               reset,
   input  logic               bus_done_i,
   input  rv_pkg::word_t      bus_rdata_i,
   input  rv_pkg::word_t      rdata1_i,
   input  rv_pkg::word_t      rdata2_i,
   input  rv_pkg::word_t      imm_i,
   input  rv_pkg::word_t      alu_result_i,
   input  logic               alu_equal_i,
   input  logic               use_imm_i,
   input  logic               write_reg_i,
   input  logic               branch_on_ne_i,
   input  rv_pkg::next_step_e step_i,
   output logic               bus_start_o,
   output logic               bus_write_o,
   output rv_pkg::word_t      bus_addr_o,
   output rv_pkg::word_t      bus_wdata_o,
   output logic               dec_load_o,
   output rv_pkg::word_t      alu_a_o,
   output rv_pkg::word_t      alu_b_o,
   output logic               rf_we_o,
   output rv_pkg::word_t      rf_wdata_o,
   output rv_pkg::word_t      pc_o,
   output logic               halted_o
);
   import rv_pkg::*;

   typedef enum logic [2:0] {
      S_FETCH,
      S_DECODE,
      S_EXECUTE,
      S_MEMORY,
      S_WRITEBACK,
      S_HALT
   } state_e;

   state_e state_q;
   state_e state_d;
   word_t  pc_q;
   word_t  pc_plus_4;
   word_t  pc_plus_imm;
   word_t  result_q;
   logic   taken_q;
   logic   issued_q;

   // ====================
   // Bus and decoder
   // ====================
   assign bus_start_o = (state_q == S_FETCH || state_q == S_MEMORY) && !issued_q;
   assign bus_write_o = (state_q == S_MEMORY) && (step_i == STEP_STORE);
   assign bus_addr_o  = (state_q == S_MEMORY) ? result_q : pc_q;
   assign bus_wdata_o = rdata2_i;
   assign dec_load_o  = (state_q == S_FETCH) && bus_done_i;

   // Immediate for arithmetic and addresses, rs2 for compares
   assign alu_a_o = rdata1_i;
   assign alu_b_o = use_imm_i ? imm_i : rdata2_i;

   // Own adders for link and target
   assign pc_plus_4   = pc_q + `RV_INSN_BYTES;
   assign pc_plus_imm = pc_q + imm_i;

   assign rf_we_o = (state_q == S_WRITEBACK) && write_reg_i;

   always_comb begin
      case (step_i)
         STEP_LOAD: rf_wdata_o = bus_rdata_i;
         STEP_JUMP: rf_wdata_o = pc_plus_4;
         default:   rf_wdata_o = result_q;
      endcase
   end

   // ====================
   // State machine
   // ====================
   always_comb begin
      state_d = state_q;
      case (state_q)
         S_FETCH: begin
            if (bus_done_i) begin
               state_d = S_DECODE;
            end
         end
         S_DECODE: state_d = S_EXECUTE;
         S_EXECUTE: begin
            case (step_i)
               STEP_LOAD, STEP_STORE: state_d = S_MEMORY;
               STEP_HALT:             state_d = S_HALT;
               default:               state_d = S_WRITEBACK;
            endcase
         end
         S_MEMORY: begin
            if (bus_done_i) begin
               state_d = S_WRITEBACK;
            end
         end
         S_WRITEBACK: state_d = S_FETCH;
         default:     state_d = S_HALT;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state_q  <= S_FETCH;
         pc_q     <= `RV_RESET_VECTOR;
         issued_q <= 1'b0;
      end else begin
         state_q <= state_d;
         if (bus_start_o) begin
            issued_q <= 1'b1;
         end else if (bus_done_i) begin
            issued_q <= 1'b0;
         end
         if (state_q == S_WRITEBACK) begin
            if (step_i == STEP_JUMP || (step_i == STEP_BRANCH && taken_q)) begin
               pc_q <= pc_plus_imm;
            end else begin
               pc_q <= pc_plus_4;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (state_q == S_EXECUTE) begin
         result_q <= alu_result_i;
         taken_q  <= alu_equal_i ^ branch_on_ne_i;
      end
   end

   assign pc_o     = pc_q;
   assign halted_o = (state_q == S_HALT);

   a_state_legal: assert property (@(posedge clk) disable iff (reset)
      state_q inside {S_FETCH, S_DECODE, S_EXECUTE, S_MEMORY, S_WRITEBACK, S_HALT});

endmodule

/* design/rv_core.sv */
module rv_core (
   input  logic          clk,
   input  logic          reset,
   input  logic          ack_i,
   input  rv_pkg::word_t dat_i,
   output rv_pkg::word_t adr_o,
   output rv_pkg::word_t dat_o,
   output logic          cyc_o,
   output logic          stb_o,
   output logic          we_o,
   output rv_pkg::word_t pc_o,
   output logic          halted_o
);

   logic               bus_start;
   logic               bus_write;
   logic               bus_done;
   rv_pkg::word_t      bus_addr;
   rv_pkg::word_t      bus_wdata;
   rv_pkg::word_t      bus_rdata;
   logic               dec_load;
   rv_pkg::reg_idx_t   rs1;
   rv_pkg::reg_idx_t   rs2;
   rv_pkg::reg_idx_t   rd;
   rv_pkg::word_t      imm;
   rv_pkg::alu_op_e    alu_op;
   logic               use_imm;
   logic               write_reg;
   logic               branch_on_ne;
   rv_pkg::next_step_e step;
   rv_pkg::word_t      alu_a;
   rv_pkg::word_t      alu_b;
   rv_pkg::word_t      alu_result;
   logic               alu_equal;
   rv_pkg::word_t      rdata1;
   rv_pkg::word_t      rdata2;
   logic               rf_we;
   rv_pkg::word_t      rf_wdata;

   rv_bus_master i_bus_master (
      .clk       (clk),
      .reset     (reset),
      .start_i   (bus_start),
      .write_i   (bus_write),
      .addr_i    (bus_addr),
      .wdata_i   (bus_wdata),
      .ack_i     (ack_i),
      .bus_dat_i (dat_i),
      .adr_o     (adr_o),
      .dat_o     (dat_o),
      .cyc_o     (cyc_o),
      .stb_o     (stb_o),
      .we_o      (we_o),
      .rdata_o   (bus_rdata),
      .done_o    (bus_done)
   );

   rv_decoder i_decoder (
      .clk            (clk),
      .reset          (reset),
      .load_i         (dec_load),
      .insn_i         (bus_rdata),
      .rs1_o          (rs1),
      .rs2_o          (rs2),
      .rd_o           (rd),
      .imm_o          (imm),
      .alu_op_o       (alu_op),
      .use_imm_o      (use_imm),
      .write_reg_o    (write_reg),
      .branch_on_ne_o (branch_on_ne),
      .step_o         (step)
   );

   rv_alu i_alu (
      .a_i      (alu_a),
      .b_i      (alu_b),
      .op_i     (alu_op),
      .result_o (alu_result),
      .equal_o  (alu_equal)
   );

   rv_regfile i_regfile (
      .clk      (clk),
      .rs1_i    (rs1),
      .rs2_i    (rs2),
      .rd_i     (rd),
      .we_i     (rf_we),
      .wdata_i  (rf_wdata),
      .rdata1_o (rdata1),
      .rdata2_o (rdata2)
   );

   rv_control i_control (
      .clk            (clk),
      .reset          (reset),
      .bus_done_i     (bus_done),
      .bus_rdata_i    (bus_rdata),
      .rdata1_i       (rdata1),
      .rdata2_i       (rdata2),
      .imm_i          (imm),
      .alu_result_i   (alu_result),
      .alu_equal_i    (alu_equal),
      .use_imm_i      (use_imm),
      .write_reg_i    (write_reg),
      .branch_on_ne_i (branch_on_ne),
      .step_i         (step),
      .bus_start_o    (bus_start),
      .bus_write_o    (bus_write),
      .bus_addr_o     (bus_addr),
      .bus_wdata_o    (bus_wdata),
      .dec_load_o     (dec_load),
      .alu_a_o        (alu_a),
      .alu_b_o        (alu_b),
      .rf_we_o        (rf_we),
      .rf_wdata_o     (rf_wdata),
      .pc_o           (pc_o),
      .halted_o       (halted_o)
   );

endmodule

/* verif/rv_core_tb.sv */
`include "rv_consts.svh"

module rv_core_tb;

   localparam int MEM_WORDS           = 256;
   localparam int MAX_CYCLES_PER_INSN = 40;
   localparam int SLACK_CYCLES        = 400;

   logic        clk;
   logic        reset;
   logic        ack_i = 1'b0;
   logic [31:0] dat_i = '0;
   logic [31:0] adr_o;
   logic [31:0] dat_o;
   logic        cyc_o;
   logic        stb_o;
   logic        we_o;
   logic [31:0] pc_o;
   logic        halted_o;

   logic [31:0] mem [MEM_WORDS];
   logic [31:0] ref_mem [MEM_WORDS];
   logic [31:0] saved_mem [MEM_WORDS];
   logic [31:0] prog [$];
   logic        random_acks = 1'b0;
   logic [31:0] lcg_state = 32'h59b3_007a;
   logic        busy = 1'b0;
   int          wait_left = 0;
   int          insn_budget = 0;

   rv_core i_rv_core (
      .clk      (clk),
      .reset    (reset),
      .ack_i    (ack_i),
      .dat_i    (dat_i),
      .adr_o    (adr_o),
      .dat_o    (dat_o),
      .cyc_o    (cyc_o),
      .stb_o    (stb_o),
      .we_o     (we_o),
      .pc_o     (pc_o),
      .halted_o (halted_o)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // ====================
   // Memory model
   // ====================
   always @(negedge clk) begin
      if (reset) begin
         ack_i <= 1'b0;
         busy = 1'b0;
      end else if (stb_o && !ack_i) begin
         // Cycle stays open for the whole strobe
         check_value("cyc_o", 32'(cyc_o), 32'd1);
         if (adr_o[31:10] != 22'd0) begin
            $display("Bus address %h lies outside the memory model", adr_o);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Bus address out of range");
         end
         if (!busy) begin
            busy = 1'b1;
            wait_left = 0;
            if (random_acks) begin
               lcg_state = lcg_next(lcg_state);
               wait_left = int'(lcg_state[18:16]);
            end
         end
         if (wait_left == 0) begin
            busy = 1'b0;
            ack_i <= 1'b1;
            if (we_o) begin
               mem[adr_o[9:2]] = dat_o;
            end else begin
               dat_i <= mem[adr_o[9:2]];
            end
         end else begin
            wait_left--;
         end
      end else begin
         ack_i <= 1'b0;
      end
   end

   initial begin : watchdog
      int cycles;
      cycles = 0;
      while (cycles < SLACK_CYCLES + insn_budget * MAX_CYCLES_PER_INSN) begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout: the core did not finish its programs in %0d cycles", cycles);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Watchdog expired");
   end

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
      if (got !== expected) begin
         $display("Error at %0t: %s is %h, expected %h", $time, name, got, expected);
         $display("TEST RESULT: FAIL");
         $fatal(1, "Mismatch on %s", name);
      end
   endtask

   // ====================
   // Instruction encoders
   // ====================
   function automatic logic [31:0] addi(input int rd, input int rs1, input int imm);
      logic [31:0] v;
      v = imm;
      return {v[11:0], 5'(rs1), `RV_F3_ADD, 5'(rd), `RV_OP_IMM};
   endfunction

   function automatic logic [31:0] alu_rr(input logic [6:0] f7, input logic [2:0] f3,
                                          input int rd, input int rs1, input int rs2);
      return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), `RV_OP_REG};
   endfunction

   function automatic logic [31:0] lui(input int rd, input int imm20);
      logic [31:0] v;
      v = imm20;
      return {v[19:0], 5'(rd), `RV_OP_LUI};
   endfunction

   function automatic logic [31:0] lw(input int rd, input int rs1, input int imm);
      logic [31:0] v;
      v = imm;
      return {v[11:0], 5'(rs1), `RV_F3_WORD, 5'(rd), `RV_OP_LOAD};
   endfunction

   function automatic logic [31:0] sw(input int rs2, input int rs1, input int imm);
      logic [31:0] v;
      v = imm;
      return {v[11:5], 5'(rs2), 5'(rs1), `RV_F3_WORD, v[4:0], `RV_OP_STORE};
   endfunction

   function automatic logic [31:0] branch(input logic [2:0] f3, input int rs1,
                                          input int rs2, input int off);
      logic [31:0] v;
      v = off;
      return {v[12], v[10:5], 5'(rs2), 5'(rs1), f3, v[4:1], v[11], `RV_OP_BRANCH};
   endfunction

   function automatic logic [31:0] jal(input int rd, input int off);
      logic [31:0] v;
      v = off;
      return {v[20], v[10:1], v[11], v[19:12], 5'(rd), `RV_OP_JAL};
   endfunction

   function automatic logic [31:0] fill_word(input logic [31:0] addr);
      return 32'hc0de_0000 + addr * 32'd3;
   endfunction

   function automatic logic [31:0] mem_at(input logic [31:0] addr);
      return mem[addr[9:2]];
   endfunction

   // ====================
   // Reference model
   // ====================
   task automatic run_reference(output logic [31:0] halt_pc);
      logic [31:0] regs [32];
      logic [31:0] pc;
      logic [31:0] insn;
      logic [31:0] sx;
      logic [31:0] src1;
      logic [31:0] src2;
      logic [31:0] addr;
      logic [2:0]  f3;
      logic [6:0]  f7;
      logic [4:0]  rd;
      logic        stop;
      int          steps;
      regs = '{default: '0};
      ref_mem = mem;
      pc = `RV_RESET_VECTOR;
      stop = 1'b0;
      steps = 0;
      while (!stop) begin
         insn = ref_mem[pc[9:2]];
         sx = {32{insn[31]}};
         f3 = insn[14:12];
         f7 = insn[31:25];
         rd = insn[11:7];
         src1 = regs[insn[19:15]];
         src2 = regs[insn[24:20]];
         case (insn[6:0])
            `RV_OP_LUI: begin
               regs[rd] = {insn[31:12], 12'h000};
               pc = pc + `RV_INSN_BYTES;
            end
            `RV_OP_JAL: begin
               regs[rd] = pc + `RV_INSN_BYTES;
               pc = pc + ((sx << 20) | 32'({insn[19:12], insn[20], insn[30:21], 1'b0}));
            end
            `RV_OP_BRANCH: begin
               if (f3 != `RV_F3_BEQ && f3 != `RV_F3_BNE) begin
                  stop = 1'b1;
               end else if ((src1 == src2) != (f3 == `RV_F3_BNE)) begin
                  pc = pc + ((sx << 12) | 32'({insn[7], insn[30:25], insn[11:8], 1'b0}));
               end else begin
                  pc = pc + `RV_INSN_BYTES;
               end
            end
            `RV_OP_LOAD: begin
               if (f3 == `RV_F3_WORD) begin
                  addr = src1 + ((sx << 11) | 32'(insn[30:20]));
                  regs[rd] = ref_mem[addr[9:2]];
                  pc = pc + `RV_INSN_BYTES;
               end else begin
                  stop = 1'b1;
               end
            end
            `RV_OP_STORE: begin
               if (f3 == `RV_F3_WORD) begin
                  addr = src1 + ((sx << 11) | 32'({insn[30:25], insn[11:7]}));
                  ref_mem[addr[9:2]] = src2;
                  pc = pc + `RV_INSN_BYTES;
               end else begin
                  stop = 1'b1;
               end
            end
            `RV_OP_IMM: begin
               if (f3 == `RV_F3_ADD) begin
                  regs[rd] = src1 + ((sx << 11) | 32'(insn[30:20]));
                  pc = pc + `RV_INSN_BYTES;
               end else begin
                  stop = 1'b1;
               end
            end
            `RV_OP_REG: begin
               if (f7 == 7'h00 && f3 == `RV_F3_ADD) regs[rd] = src1 + src2;
               else if (f7 == 7'h20 && f3 == `RV_F3_ADD) regs[rd] = src1 - src2;
               else if (f7 == 7'h00 && f3 == `RV_F3_XOR) regs[rd] = src1 ^ src2;
               else if (f7 == 7'h00 && f3 == `RV_F3_OR) regs[rd] = src1 | src2;
               else if (f7 == 7'h00 && f3 == `RV_F3_AND) regs[rd] = src1 & src2;
               else stop = 1'b1;
               if (!stop) begin
                  pc = pc + `RV_INSN_BYTES;
               end
            end
            default: stop = 1'b1;
         endcase
         regs[0] = '0;
         steps++;
         if (steps > 1000) begin
            $display("Reference model ran 1000 steps without reaching a halt");
            $display("TEST RESULT: FAIL");
            $fatal(1, "Reference model runaway");
         end
      end
      halt_pc = pc;
   endtask

   // ====================
   // Sequencing helpers
   // ====================
   task automatic apply_reset();
      @(negedge clk);
      reset = 1'b1;
      repeat (4) @(negedge clk);
      reset = 1'b0;
   endtask

   // Fill first, then the program image from address 0
   task automatic load_program();
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem[i[7:0]] = fill_word(i * 4);
      end
      for (int i = 0; i < prog.size(); i++) begin
         mem[i[7:0]] = prog[i];
      end
      insn_budget += prog.size();
   endtask

   task automatic compare_memory();
      for (int i = 0; i < MEM_WORDS; i++) begin
         check_value($sformatf("mem[0x%03h]", i * 4), mem[i[7:0]], ref_mem[i[7:0]]);
      end
   endtask

   task automatic execute_program(input logic random_delay);
      logic [31:0] halt_pc;
      run_reference(halt_pc);
      random_acks = random_delay;
      apply_reset();
      while (!halted_o) @(negedge clk);
      check_value("pc_o", pc_o, halt_pc);
      compare_memory();
   endtask

   task automatic build_arith_program();
      prog.delete();
      prog.push_back(addi(1, 0, 100));
      prog.push_back(addi(2, 0, -7));
      prog.push_back(alu_rr(7'h00, `RV_F3_ADD, 3, 1, 2));
      prog.push_back(alu_rr(7'h20, `RV_F3_ADD, 4, 1, 2));
      prog.push_back(alu_rr(7'h00, `RV_F3_AND, 5, 1, 2));
      prog.push_back(alu_rr(7'h00, `RV_F3_OR, 6, 1, 2));
      prog.push_back(alu_rr(7'h00, `RV_F3_XOR, 7, 1, 2));
      prog.push_back(lui(8, 32'habcde));
      prog.push_back(addi(9, 8, -1));
      for (int r = 1; r <= 9; r++) begin
         prog.push_back(sw(r, 0, 32'h2fc + r * 4));
      end
      prog.push_back(32'h0000_0000);
   endtask

   // ====================
   // Directed tests
   // ====================
   task automatic check_reset_state();
      prog.delete();
      prog.push_back(32'h0000_0000);
      load_program();
      apply_reset();
      check_value("cyc_o", 32'(cyc_o), 32'd0);
      check_value("stb_o", 32'(stb_o), 32'd0);
      check_value("we_o", 32'(we_o), 32'd0);
      check_value("halted_o", 32'(halted_o), 32'd0);
      check_value("pc_o", pc_o, `RV_RESET_VECTOR);
      while (!stb_o) @(negedge clk);
      check_value("adr_o", adr_o, `RV_RESET_VECTOR);
      check_value("we_o", 32'(we_o), 32'd0);
      while (!halted_o) @(negedge clk);
      check_value("pc_o", pc_o, `RV_RESET_VECTOR);
   endtask

   task automatic run_arith_program();
      build_arith_program();
      load_program();
      execute_program(1'b0);
      // 100 - (-7)
      check_value("mem[0x30c]", mem_at(32'h30c), 32'd107);
      saved_mem = mem;
   endtask

   task automatic run_load_program();
      prog.delete();
      prog.push_back(lw(1, 0, 32'h200));
      prog.push_back(lw(2, 0, 32'h204));
      prog.push_back(alu_rr(7'h00, `RV_F3_ADD, 3, 1, 2));
      prog.push_back(addi(0, 1, 5));
      prog.push_back(alu_rr(7'h00, `RV_F3_ADD, 0, 1, 2));
      prog.push_back(sw(0, 0, 32'h310));
      prog.push_back(sw(3, 0, 32'h314));
      prog.push_back(lw(4, 0, 32'h314));
      prog.push_back(sw(4, 0, 32'h318));
      prog.push_back(32'h0000_0000);
      load_program();
      mem[8'h80] = 32'h1234_5678;
      mem[8'h81] = 32'h0000_1111;
      execute_program(1'b0);
      check_value("mem[0x310]", mem_at(32'h310), 32'd0);
      check_value("mem[0x314]", mem_at(32'h314), 32'h1234_6789);
   endtask

   task automatic run_branch_program();
      prog.delete();
      prog.push_back(addi(1, 0, 5));
      prog.push_back(addi(2, 0, 5));
      prog.push_back(addi(3, 0, 9));
      prog.push_back(addi(10, 0, 1));
      prog.push_back(branch(`RV_F3_BEQ, 1, 2, 12));
      prog.push_back(sw(10, 0, 32'h300));
      prog.push_back(sw(10, 0, 32'h304));
      prog.push_back(branch(`RV_F3_BNE, 1, 3, 8));
      prog.push_back(sw(10, 0, 32'h308));
      prog.push_back(branch(`RV_F3_BEQ, 1, 3, 8));
      prog.push_back(sw(10, 0, 32'h30c));
      prog.push_back(branch(`RV_F3_BNE, 1, 2, 8));
      prog.push_back(sw(10, 0, 32'h310));
      // JAL at 0x34 skips two markers
      prog.push_back(jal(5, 12));
      prog.push_back(sw(10, 0, 32'h314));
      prog.push_back(sw(10, 0, 32'h318));
      prog.push_back(sw(5, 0, 32'h31c));
      // Backward branch, three trips
      prog.push_back(addi(6, 0, 3));
      prog.push_back(addi(6, 6, -1));
      prog.push_back(branch(`RV_F3_BNE, 6, 0, -4));
      prog.push_back(sw(6, 0, 32'h320));
      prog.push_back(32'h0000_0000);
      load_program();
      execute_program(1'b0);
      check_value("mem[0x300]", mem_at(32'h300), fill_word(32'h300));
      check_value("mem[0x30c]", mem_at(32'h30c), 32'd1);
      check_value("mem[0x31c]", mem_at(32'h31c), 32'h34 + `RV_INSN_BYTES);
   endtask

   task automatic run_backpressure();
      build_arith_program();
      load_program();
      execute_program(1'b1);
      for (int i = 0; i < MEM_WORDS; i++) begin
         check_value($sformatf("mem[0x%03h]", i * 4), mem[i[7:0]], saved_mem[i[7:0]]);
      end
   endtask

   task automatic check_halt();
      prog.delete();
      prog.push_back(addi(1, 0, 1));
      prog.push_back(sw(1, 0, 32'h300));
      prog.push_back(32'h0000_007f);
      prog.push_back(addi(2, 0, 2));
      prog.push_back(sw(2, 0, 32'h304));
      load_program();
      execute_program(1'b0);
      check_value("pc_o", pc_o, 32'h8);
      repeat (50) begin
         @(negedge clk);
         check_value("cyc_o", 32'(cyc_o), 32'd0);
         check_value("halted_o", 32'(halted_o), 32'd1);
         check_value("pc_o", pc_o, 32'h8);
      end
   endtask

   initial begin
      reset = 1'b1;
      check_reset_state();
      run_arith_program();
      run_load_program();
      run_branch_program();
      run_backpressure();
      check_halt();
      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

/* sources.f */
+incdir+design
design/rv_pkg.sv
design/rv_bus_master.sv
design/rv_decoder.sv
design/rv_alu.sv
design/rv_regfile.sv
design/rv_control.sv
design/rv_core.sv
verif/rv_core_tb.sv

/* Makefile */
TOP := rv_core_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): sources.f design/*.sv design/*.svh verif/*.sv
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f

lint:
	verilator --lint-only --timing -Wall --top-module rv_core -f sources.f

clean:
	rm -rf obj_dir
